// File: hdl/bb_pkg.sv
package bb_pkg;

  typedef logic [2:0] lt_addr_t;
  typedef logic [7:0] hec_t;
  typedef logic [6:0] whiten_t;

  typedef enum logic [3:0] {
    PK_NULL = 4'd0,
    PK_POLL = 4'd1,
    PK_FHS  = 4'd2,
    PK_DM1  = 4'd3,
    PK_DH1  = 4'd4
  } pk_type_t;

  localparam int   HDR_BITS = 10;
  localparam int   HEC_BITS = 8;
  localparam int   AIR_BITS = HDR_BITS + HEC_BITS;
  localparam hec_t HEC_POLY = 8'ha7;  // D^8+D^7+D^5+D^2+D+1

  // one serial step of the header check
  function automatic hec_t hec_step(hec_t crc, logic din);
    logic fb;
    fb = din ^ crc[7];
    hec_step = {crc[6:0], 1'b0} ^ (fb ? HEC_POLY : 8'h00);
  endfunction

  function automatic pk_type_t to_pk_type(logic [3:0] code);
    if (code <= 4'(PK_DH1))
      return pk_type_t'(code);
    return PK_NULL;  // undefined codes
  endfunction

  function automatic logic is_data(pk_type_t t);
    return (t == PK_DM1) || (t == PK_DH1);
  endfunction

endpackage

// File: hdl/bb_reg_pkg.sv
package bb_reg_pkg;

  typedef enum logic [2:0] {
    REG_LT_ADDR = 3'd0,
    REG_PK_TYPE = 3'd1,
    REG_UAP     = 3'd2,
    REG_WHITEN  = 3'd3,  // [7] enable, [6:0] init
    REG_FLOW    = 3'd4
  } reg_addr_t;

  localparam int REG_DATA_BITS = 8;

  localparam bb_pkg::lt_addr_t RST_LT_ADDR     = 3'd1;
  localparam bb_pkg::pk_type_t RST_PK_TYPE     = bb_pkg::PK_NULL;
  localparam logic [7:0]       RST_UAP         = 8'h00;
  localparam logic             RST_WHITEN_EN   = 1'b1;
  localparam bb_pkg::whiten_t  RST_WHITEN_INIT = 7'h7f;
  localparam logic             RST_FLOW        = 1'b1;

endpackage

// File: hdl/bb_regs.sv
`timescale 1ns/100ps
module bb_regs (
  input  logic                                 clk_6M,
  input  logic                                 rstz,
  input  logic                                 reg_we,
  input  bb_reg_pkg::reg_addr_t                reg_addr,
  input  logic [bb_reg_pkg::REG_DATA_BITS-1:0] reg_wdata,
  output bb_pkg::lt_addr_t                     my_lt_addr,
  output bb_pkg::pk_type_t                     tx_pk_type,
  output logic [7:0]                           uap,
  output logic                                 whiten_en,
  output bb_pkg::whiten_t                      whiten_init,
  output logic                                 tx_flow
);
  import bb_pkg::*;
  import bb_reg_pkg::*;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      my_lt_addr  <= RST_LT_ADDR;
      tx_pk_type  <= RST_PK_TYPE;
      uap         <= RST_UAP;
      whiten_en   <= RST_WHITEN_EN;
      whiten_init <= RST_WHITEN_INIT;
      tx_flow     <= RST_FLOW;
    end
    else if (reg_we)
    begin
      case (reg_addr)
        REG_LT_ADDR: my_lt_addr <= reg_wdata[2:0];
        REG_PK_TYPE:
        begin
          if (reg_wdata[7:4] == 4'h0)
            tx_pk_type <= to_pk_type(reg_wdata[3:0]);
          else
            tx_pk_type <= PK_NULL;
        end
        REG_UAP:     uap <= reg_wdata;
        REG_WHITEN:
        begin
          whiten_en   <= reg_wdata[7];
          whiten_init <= reg_wdata[6:0];
        end
        REG_FLOW:    tx_flow <= reg_wdata[0];
        default:     ;  // unmapped, dropped
      endcase
    end
  end

endmodule

// File: hdl/whiten_lfsr.sv
`timescale 1ns/100ps
module whiten_lfsr (
  input  logic            clk_6M,
  input  logic            rstz,
  input  logic            load,
  input  bb_pkg::whiten_t init,
  input  logic            step,
  output logic            wbit
);
  import bb_pkg::*;

  whiten_t state;

  // x^7 + x^4 + 1
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= '1;
    else if (load)
      state <= {1'b1, init[5:0]};  // msb forced, never all zero
    else if (step)
      state <= {state[5:0], state[6] ^ state[3]};
  end

  assign wbit = state[6];

endmodule

// File: hdl/header_tx.sv
`timescale 1ns/100ps
module header_tx (
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             p_1us,
  input  logic             tx_start,
  input  bb_pkg::lt_addr_t my_lt_addr,
  input  bb_pkg::pk_type_t tx_pk_type,
  input  logic [7:0]       uap,
  input  logic             whiten_en,
  input  bb_pkg::whiten_t  whiten_init,
  input  logic             tx_flow,
  input  logic             tx_arqn,
  input  logic             tx_seqn,
  output logic             txbit,
  output logic             tx_busy,
  output logic             tx_done
);
  import bb_pkg::*;

  logic [HDR_BITS-1:0] hdr_sr;
  hec_t                hec;
  logic [4:0]          bit_cnt;
  logic                wbit;
  logic                start_ok;
  logic                bit_p;
  logic                cur_bit;

  assign start_ok = tx_start & ~tx_busy;  // ignored while busy
  assign bit_p    = p_1us & tx_busy;
  assign cur_bit  = (bit_cnt < HDR_BITS) ? hdr_sr[0] : hec[7];

  whiten_lfsr whiten_u (
    .clk_6M (clk_6M     ),
    .rstz   (rstz       ),
    .load   (start_ok   ),
    .init   (whiten_init),
    .step   (bit_p      ),
    .wbit   (wbit       )
  );

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
      bit_cnt <= '0;
      txbit   <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (start_ok)
      begin
        tx_busy <= 1'b1;
        bit_cnt <= '0;
      end
      else if (bit_p)
      begin
        txbit <= cur_bit ^ (whiten_en & wbit);
        if (bit_cnt == AIR_BITS - 1)
        begin
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
          bit_cnt <= '0;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // header LSB first, then hec msb first
  always_ff @(posedge clk_6M)
  begin
    if (start_ok)
    begin
      hdr_sr <= {tx_seqn, tx_arqn, tx_flow, tx_pk_type, my_lt_addr};
      hec    <= uap;
    end
    else if (bit_p)
    begin
      if (bit_cnt < HDR_BITS)
      begin
        hdr_sr <= hdr_sr >> 1;
        hec    <= hec_step(hec, hdr_sr[0]);
      end
      else
        hec <= hec << 1;
    end
  end

  a_bit_cnt_range: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_busy |-> (bit_cnt < AIR_BITS));

endmodule

// File: hdl/header_rx.sv
`timescale 1ns/100ps
module header_rx (
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             p_1us,
  input  logic             rx_start,
  input  logic             rxbit,
  input  logic [7:0]       uap,
  input  logic             whiten_en,
  input  bb_pkg::whiten_t  whiten_init,
  output logic             rx_valid,
  output bb_pkg::lt_addr_t dec_lt_addr,
  output bb_pkg::pk_type_t dec_pk_type,
  output logic             dec_flow,
  output logic             dec_arqn,
  output logic             dec_seqn,
  output logic             hec_good
);
  import bb_pkg::*;

  logic                armed;
  logic [4:0]          bit_cnt;
  logic [HDR_BITS-1:0] hdr_sr;
  hec_t                hec_calc;
  hec_t                hec_rx;
  logic                wbit;
  logic                samp_p;
  logic                dbit;
  logic                last_p;

  assign samp_p = p_1us & armed & ~rx_start;  // restart wins
  assign dbit   = rxbit ^ (whiten_en & wbit);
  assign last_p = samp_p & (bit_cnt == AIR_BITS - 1);

  whiten_lfsr whiten_u (
    .clk_6M (clk_6M     ),
    .rstz   (rstz       ),
    .load   (rx_start   ),
    .init   (whiten_init),
    .step   (samp_p     ),
    .wbit   (wbit       )
  );

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      armed    <= 1'b0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= last_p;
      if (rx_start)
      begin
        armed   <= 1'b1;
        bit_cnt <= '0;
      end
      else if (last_p)
      begin
        armed   <= 1'b0;
        bit_cnt <= '0;
      end
      else if (samp_p)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (rx_start)
      hec_calc <= uap;
    else if (samp_p)
    begin
      if (bit_cnt < HDR_BITS)
      begin
        hdr_sr   <= {dbit, hdr_sr[HDR_BITS-1:1]};
        hec_calc <= hec_step(hec_calc, dbit);
      end
      else
        hec_rx <= {hec_rx[HEC_BITS-2:0], dbit};
    end
    // last hec bit arrives with last_p
    if (last_p)
    begin
      dec_lt_addr <= hdr_sr[2:0];
      dec_pk_type <= to_pk_type(hdr_sr[6:3]);
      dec_flow    <= hdr_sr[7];
      dec_arqn    <= hdr_sr[8];
      dec_seqn    <= hdr_sr[9];
      hec_good    <= (hec_calc == {hec_rx[HEC_BITS-2:0], dbit});
    end
  end

  a_valid_single: assert property (@(posedge clk_6M) disable iff (!rstz)
    rx_valid |=> !rx_valid);

endmodule

// File: hdl/arq_ctrl.sv
`timescale 1ns/100ps
module arq_ctrl (
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             rx_valid,
  input  bb_pkg::lt_addr_t my_lt_addr,
  input  bb_pkg::lt_addr_t dec_lt_addr,
  input  bb_pkg::pk_type_t dec_pk_type,
  input  logic             dec_arqn,
  input  logic             dec_seqn,
  input  logic             hec_good,
  output logic             tx_arqn,
  output logic             tx_seqn,
  output logic             rx_new,
  output logic             rx_dup
);
  import bb_pkg::*;

  logic seqn_old;
  logic addressed;

  assign addressed = hec_good & (dec_lt_addr == my_lt_addr);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_arqn  <= 1'b0;
      tx_seqn  <= 1'b0;
      rx_new   <= 1'b0;
      rx_dup   <= 1'b0;
      seqn_old <= 1'b1;  // first seqn 0 is new
    end
    else
    begin
      rx_new <= 1'b0;
      rx_dup <= 1'b0;
      if (rx_valid)
      begin
        if (!addressed)
          tx_arqn <= 1'b0;  // nak
        else
        begin
          if (is_data(dec_pk_type))
          begin
            tx_arqn <= 1'b1;
            if (dec_seqn != seqn_old)
            begin
              rx_new   <= 1'b1;
              seqn_old <= dec_seqn;
            end
            else
              rx_dup <= 1'b1;
          end
          if (dec_arqn)
            tx_seqn <= ~tx_seqn;  // peer acked, next packet
        end
      end
    end
  end

  a_new_dup_excl: assert property (@(posedge clk_6M) disable iff (!rstz)
    !(rx_new && rx_dup));

endmodule

// File: hdl/bb_top.sv
`timescale 1ns/100ps
module bb_top (
  input  logic                                 clk_6M,
  input  logic                                 rstz,
  input  logic                                 p_1us,
  input  logic                                 reg_we,
  input  bb_reg_pkg::reg_addr_t                reg_addr,
  input  logic [bb_reg_pkg::REG_DATA_BITS-1:0] reg_wdata,
  input  logic                                 tx_start,
  input  logic                                 rx_start,
  input  logic                                 rxbit,
  output logic                                 txbit,
  output logic                                 tx_busy,
  output logic                                 tx_done,
  output logic                                 rx_valid,
  output bb_pkg::lt_addr_t                     dec_lt_addr,
  output bb_pkg::pk_type_t                     dec_pk_type,
  output logic                                 dec_flow,
  output logic                                 dec_arqn,
  output logic                                 dec_seqn,
  output logic                                 hec_good,
  output logic                                 rx_new,
  output logic                                 rx_dup
);
  import bb_pkg::*;

  lt_addr_t   my_lt_addr;
  pk_type_t   tx_pk_type;
  logic [7:0] uap;
  logic       whiten_en;
  whiten_t    whiten_init;
  logic       tx_flow;
  logic       tx_arqn;
  logic       tx_seqn;

  bb_regs regs_u (
    .clk_6M      (clk_6M     ),
    .rstz        (rstz       ),
    .reg_we      (reg_we     ),
    .reg_addr    (reg_addr   ),
    .reg_wdata   (reg_wdata  ),
    .my_lt_addr  (my_lt_addr ),
    .tx_pk_type  (tx_pk_type ),
    .uap         (uap        ),
    .whiten_en   (whiten_en  ),
    .whiten_init (whiten_init),
    .tx_flow     (tx_flow    )
  );

  header_tx header_tx_u (
    .clk_6M      (clk_6M     ),
    .rstz        (rstz       ),
    .p_1us       (p_1us      ),
    .tx_start    (tx_start   ),
    .my_lt_addr  (my_lt_addr ),
    .tx_pk_type  (tx_pk_type ),
    .uap         (uap        ),
    .whiten_en   (whiten_en  ),
    .whiten_init (whiten_init),
    .tx_flow     (tx_flow    ),
    .tx_arqn     (tx_arqn    ),
    .tx_seqn     (tx_seqn    ),
    .txbit       (txbit      ),
    .tx_busy     (tx_busy    ),
    .tx_done     (tx_done    )
  );

  header_rx header_rx_u (
    .clk_6M      (clk_6M     ),
    .rstz        (rstz       ),
    .p_1us       (p_1us      ),
    .rx_start    (rx_start   ),
    .rxbit       (rxbit      ),
    .uap         (uap        ),
    .whiten_en   (whiten_en  ),
    .whiten_init (whiten_init),
    .rx_valid    (rx_valid   ),
    .dec_lt_addr (dec_lt_addr),
    .dec_pk_type (dec_pk_type),
    .dec_flow    (dec_flow   ),
    .dec_arqn    (dec_arqn   ),
    .dec_seqn    (dec_seqn   ),
    .hec_good    (hec_good   )
  );

  arq_ctrl arq_ctrl_u (
    .clk_6M      (clk_6M     ),
    .rstz        (rstz       ),
    .rx_valid    (rx_valid   ),
    .my_lt_addr  (my_lt_addr ),
    .dec_lt_addr (dec_lt_addr),
    .dec_pk_type (dec_pk_type),
    .dec_arqn    (dec_arqn   ),
    .dec_seqn    (dec_seqn   ),
    .hec_good    (hec_good   ),
    .tx_arqn     (tx_arqn    ),
    .tx_seqn     (tx_seqn    ),
    .rx_new      (rx_new     ),
    .rx_dup      (rx_dup     )
  );

endmodule

// File: tb/tb_bb_top.sv
`timescale 1ns/100ps
module tb_bb_top;
  import bb_pkg::*;
  import bb_reg_pkg::*;

  localparam logic [7:0] hec_gen = 8'b1010_0111;  // d^8 + d^7 + d^5 + d^2 + d + 1
  localparam int strobe_limit = 18 * 6 + 24;

  logic       clk_6M;
  logic       rstz;
  logic       p_1us = 1'b0;
  logic [2:0] p_cnt = '0;
  logic       reg_we;
  reg_addr_t  reg_addr;
  logic [7:0] reg_wdata;
  logic       tx_start;
  logic       rx_start;
  logic       rxbit;
  logic       txbit;
  logic       tx_busy;
  logic       tx_done;
  logic       rx_valid;
  lt_addr_t   dec_lt_addr;
  pk_type_t   dec_pk_type;
  logic       dec_flow;
  logic       dec_arqn;
  logic       dec_seqn;
  logic       hec_good;
  logic       rx_new;
  logic       rx_dup;

  // model state
  lt_addr_t   m_lt_addr;
  pk_type_t   m_pk_type;
  logic [7:0] m_uap;
  logic       m_wen;
  whiten_t    m_winit;
  logic       m_flow;
  logic       m_arqn;
  logic       m_seqn;
  logic       m_seqn_old;

  logic [15:0] rng;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          errors_before = 0;
  logic        timed_out = 1'b0;

  bb_top dut0 (
    .clk_6M      (clk_6M     ),
    .rstz        (rstz       ),
    .p_1us       (p_1us      ),
    .reg_we      (reg_we     ),
    .reg_addr    (reg_addr   ),
    .reg_wdata   (reg_wdata  ),
    .tx_start    (tx_start   ),
    .rx_start    (rx_start   ),
    .rxbit       (rxbit      ),
    .txbit       (txbit      ),
    .tx_busy     (tx_busy    ),
    .tx_done     (tx_done    ),
    .rx_valid    (rx_valid   ),
    .dec_lt_addr (dec_lt_addr),
    .dec_pk_type (dec_pk_type),
    .dec_flow    (dec_flow   ),
    .dec_arqn    (dec_arqn   ),
    .dec_seqn    (dec_seqn   ),
    .hec_good    (hec_good   ),
    .rx_new      (rx_new     ),
    .rx_dup      (rx_dup     )
  );

  always #5 clk_6M = ~clk_6M;

  // bit strobe every 6 clocks
  always @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      p_cnt <= '0;
      p_1us <= 1'b0;
    end
    else
    begin
      p_cnt <= (p_cnt == 3'd5) ? 3'd0 : p_cnt + 1'b1;
      p_1us <= (p_cnt == 3'd5);
    end
  end

  // galois lfsr with taps 16 14 13 11
  function automatic logic rand_bit();
    logic b;
    b = rng[0];
    rng = rng >> 1;
    if (b)
      rng = rng ^ 16'hb400;
    return b;
  endfunction

  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v[i] = rand_bit();
    return v;
  endfunction

  function automatic pk_type_t type_of(logic [3:0] c);
    if (c <= 4'd4)
      return pk_type_t'(c);
    return PK_NULL;
  endfunction

  function automatic logic [9:0] pack_hdr(lt_addr_t a, pk_type_t t, logic flow, logic arqn,
                                          logic seqn);
    return {seqn, arqn, flow, t, a};
  endfunction

  function automatic logic [7:0] model_hec(logic [7:0] init, logic [9:0] h);
    logic [7:0] r;
    logic       fb;
    r = init;
    for (int i = 0; i < 10; i++)
    begin
      fb = h[i] ^ r[7];
      r = {r[6:0], 1'b0} ^ (fb ? hec_gen : 8'h00);
    end
    return r;
  endfunction

  // bit k of the result is the k-th bit on air
  function automatic logic [17:0] air_bits(logic [9:0] h, logic [7:0] u, logic wen,
                                           whiten_t winit);
    logic [17:0] b;
    logic [7:0]  hec;
    logic [6:0]  st;
    hec = model_hec(u, h);
    b[9:0] = h;
    for (int j = 0; j < 8; j++)
      b[10 + j] = hec[7 - j];
    st = {1'b1, winit[5:0]};
    for (int k = 0; k < 18; k++)
    begin
      b[k] = b[k] ^ (wen & st[6]);
      st = {st[5:0], st[6] ^ st[3]};
    end
    return b;
  endfunction

  task automatic check_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_lt_addr(lt_addr_t got, lt_addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error %0t ns: dec_lt_addr is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_pk_type(pk_type_t got, pk_type_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error %0t ns: dec_pk_type is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_hec_good(logic got, logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error %0t ns: hec_good is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_arq_flags(logic new_got, logic dup_got, logic new_exp, logic dup_exp);
    checks++;
    if (new_got !== new_exp || dup_got !== dup_exp)
    begin
      errors++;
      $display("** Error %0t ns: rx_new/rx_dup are %b/%b, expected %b/%b", $time,
               new_got, dup_got, new_exp, dup_exp);
    end
  endtask

  task automatic timeout_hit(string sig);
    $display("timeout: %s never came", sig);
    timed_out = 1'b1;
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("%-22s %s, %0d errors", name, (errors == errors_before) ? "pass" : "fail",
             errors - errors_before);
    errors_before = errors;
  endtask

  task automatic reg_write(reg_addr_t a, logic [7:0] d);
    @(posedge clk_6M);
    reg_we    <= 1'b1;
    reg_addr  <= a;
    reg_wdata <= d;
    @(posedge clk_6M);
    reg_we <= 1'b0;
    case (a)
      REG_LT_ADDR: m_lt_addr = d[2:0];
      REG_PK_TYPE: m_pk_type = (d[7:4] == 4'h0) ? type_of(d[3:0]) : PK_NULL;
      REG_UAP:     m_uap = d;
      REG_WHITEN:
      begin
        m_wen   = d[7];
        m_winit = d[6:0];
      end
      REG_FLOW:    m_flow = d[0];
      default:     ;
    endcase
  endtask

  task automatic tx_check();
    logic [17:0] exp;
    logic        seen;
    int          n;
    int          cyc;
    if (timed_out)
      return;
    exp = air_bits(pack_hdr(m_lt_addr, m_pk_type, m_flow, m_arqn, m_seqn), m_uap, m_wen,
                   m_winit);
    @(posedge clk_6M);
    tx_start <= 1'b1;
    @(posedge clk_6M);
    tx_start <= 1'b0;
    seen = 1'b0;
    n = 0;
    cyc = 0;
    while (n < AIR_BITS && cyc < strobe_limit)
    begin
      @(posedge clk_6M);
      cyc++;
      if (seen)
      begin
        check_bit($sformatf("txbit %0d", n), txbit, exp[n]);
        n++;
      end
      seen = p_1us && tx_busy;  // txbit updates on this edge
    end
    if (n < AIR_BITS)
      timeout_hit("tx bit strobe");
    else
    begin
      check_bit("tx_done", tx_done, 1'b1);
      check_bit("tx_busy", tx_busy, 1'b0);
    end
  endtask

  task automatic rx_check(logic [9:0] h, int flip);
    logic [17:0] air;
    int          n;
    int          cyc;
    logic        valid_seen;
    logic        good;
    logic        new_e;
    logic        dup_e;
    pk_type_t    t_exp;
    if (timed_out)
      return;
    air = air_bits(h, m_uap, m_wen, m_winit);
    if (flip >= 0)
      air[flip] = ~air[flip];
    good = (flip < 0);
    t_exp = type_of(h[6:3]);
    @(posedge clk_6M);
    rx_start <= 1'b1;
    rxbit    <= air[0];
    @(posedge clk_6M);
    rx_start <= 1'b0;
    n = 0;
    cyc = 0;
    while (n < AIR_BITS && cyc < strobe_limit)
    begin
      @(posedge clk_6M);
      cyc++;
      if (p_1us)
      begin
        n++;
        if (n < AIR_BITS)
          rxbit <= air[n];
      end
    end
    valid_seen = 1'b0;
    cyc = 0;
    while (!valid_seen && cyc < 20)
    begin
      @(posedge clk_6M);
      cyc++;
      valid_seen = rx_valid;
    end
    if (n < AIR_BITS || !valid_seen)
    begin
      timeout_hit((n < AIR_BITS) ? "rx bit strobe" : "rx_valid");
      return;
    end
    check_hec_good(hec_good, good);
    if (good)
    begin
      check_lt_addr(dec_lt_addr, h[2:0]);
      check_pk_type(dec_pk_type, t_exp);
      check_bit("dec_flow", dec_flow, h[7]);
      check_bit("dec_arqn", dec_arqn, h[8]);
      check_bit("dec_seqn", dec_seqn, h[9]);
    end
    new_e = 1'b0;
    dup_e = 1'b0;
    if (!(good && h[2:0] == m_lt_addr))
      m_arqn = 1'b0;
    else
    begin
      if (t_exp == PK_DM1 || t_exp == PK_DH1)
      begin
        m_arqn = 1'b1;
        if (h[9] != m_seqn_old)
        begin
          new_e = 1'b1;
          m_seqn_old = h[9];
        end
        else
          dup_e = 1'b1;
      end
      if (h[8])
        m_seqn = ~m_seqn;
    end
    @(posedge clk_6M);  // arq outputs settle one clock after rx_valid
    check_arq_flags(rx_new, rx_dup, new_e, dup_e);
  endtask

  initial
  begin
    logic [5:0] seqn_pat;
    logic       a;
    logic       f;
    pk_type_t   t;
    clk_6M    = 1'b0;
    rstz      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = REG_LT_ADDR;
    reg_wdata = '0;
    tx_start  = 1'b0;
    rx_start  = 1'b0;
    rxbit     = 1'b0;
    rng       = 16'd41122;
    m_lt_addr = 3'd1;
    m_pk_type = PK_NULL;
    m_uap     = 8'h00;
    m_wen     = 1'b1;
    m_winit   = 7'h7f;
    m_flow    = 1'b1;
    m_arqn    = 1'b0;
    m_seqn    = 1'b0;
    m_seqn_old = 1'b1;
    repeat (4) @(posedge clk_6M);
    rstz <= 1'b1;
    repeat (2) @(posedge clk_6M);

    tx_check();  // reset values
    for (int i = 0; i < 6; i++)
    begin
      for (int j = 0; j < 3; j++)
        reg_write(reg_addr_t'(rand_bits(3)), 8'(rand_bits(8)));  // 5..7 unmapped
      reg_write(REG_PK_TYPE, 8'(rand_bits(3)));
      tx_check();
    end
    finish_test("tx random regs");

    reg_write(REG_WHITEN, {1'b1, 7'(rand_bits(7))});  // rx sees whitened bits
    for (int i = 0; i < 6; i++)
      rx_check(10'(rand_bits(10)), -1);
    finish_test("rx random header");

    for (int i = 0; i < 4; i++)
    begin
      rx_check(10'(rand_bits(10)), int'(rand_bits(5)) % AIR_BITS);
      tx_check();  // arqn must be 0
    end
    finish_test("rx hec error");

    reg_write(REG_LT_ADDR, 8'(rand_bits(3)));
    seqn_pat = 6'b101100;
    for (int i = 0; i < 6; i++)
    begin
      a = rand_bit();
      f = rand_bit();
      t = rand_bit() ? PK_DH1 : PK_DM1;
      rx_check(pack_hdr(m_lt_addr, t, f, a, seqn_pat[i]), -1);
      tx_check();
    end
    finish_test("arq seqn sequence");

    reg_write(REG_WHITEN, {1'b0, 7'(rand_bits(7))});
    tx_check();
    rx_check(pack_hdr(m_lt_addr, PK_DM1, 1'b1, 1'b0, rand_bit()), -1);
    rx_check(pack_hdr(m_lt_addr + 3'd1, PK_DH1, 1'b1, 1'b1, rand_bit()), -1);
    tx_check();
    finish_test("plain and other addr");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sim.f
hdl/bb_pkg.sv
hdl/bb_reg_pkg.sv
hdl/bb_regs.sv
hdl/whiten_lfsr.sv
hdl/header_tx.sv
hdl/header_rx.sv
hdl/arq_ctrl.sv
hdl/bb_top.sv
tb/tb_bb_top.sv

// File: Bender.yml
package:
  name: bb_header

sources:
  - files:
      - hdl/bb_pkg.sv
      - hdl/bb_reg_pkg.sv
      - hdl/bb_regs.sv
      - hdl/whiten_lfsr.sv
      - hdl/header_tx.sv
      - hdl/header_rx.sv
      - hdl/arq_ctrl.sv
      - hdl/bb_top.sv
  - target: test
    files:
      - tb/tb_bb_top.sv
